/* tb.f */
logic/bip_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/datapath.sv
logic/data_memory.sv
logic/accumulator_cpu.sv
bench/datapath_assert.sv
bench/tb_accumulator_cpu.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the accumulator cpu testbench with verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_accumulator_cpu -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* bench/tb_accumulator_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_accumulator_cpu;

  typedef struct packed {
    logic [bip_pkg::DATA_ADDR_WIDTH-1:0] addr;
    logic [bip_pkg::DATA_WIDTH-1:0] data;
  } store_t;

  logic i_clock;
  logic i_reset;
  logic i_start;
  logic i_load_en;
  logic [bip_pkg::PC_WIDTH-1:0] i_load_addr;
  logic [bip_pkg::DATA_WIDTH-1:0] i_load_word;
  logic [bip_pkg::DATA_WIDTH-1:0] o_acc;
  logic [bip_pkg::PC_WIDTH-1:0] o_pc;
  logic o_halted;
  logic o_store_valid;
  logic [bip_pkg::DATA_ADDR_WIDTH-1:0] o_store_addr;
  logic [bip_pkg::DATA_WIDTH-1:0] o_store_data;

  logic [bip_pkg::DATA_WIDTH-1:0] program_words [$];
  logic [bip_pkg::DATA_WIDTH-1:0] model_mem [bip_pkg::DATA_DEPTH];
  logic [bip_pkg::DATA_WIDTH-1:0] model_acc;
  store_t expected_stores [$];
  store_t seen_stores [$];
  int written_addrs [$];
  int error_count;
  int assert_fails;
  int cycle_count;
  int seed;

  accumulator_cpu accumulator_cpu_inst (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_start       (i_start),
    .i_load_en     (i_load_en),
    .i_load_addr   (i_load_addr),
    .i_load_word   (i_load_word),
    .o_acc         (o_acc),
    .o_pc          (o_pc),
    .o_halted      (o_halted),
    .o_store_valid (o_store_valid),
    .o_store_addr  (o_store_addr),
    .o_store_data  (o_store_data)
  );

  always #20 i_clock = ~i_clock;

  // two full programs plus start and drain margins, with slack.
  always @(posedge i_clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 400) begin
      $display("timeout: the programs did not finish within 400 cycles");
      $display("*** FAILED ***");
      $finish;
    end
  end

  always @(negedge i_clock) begin
    if (i_reset && o_store_valid) begin
      seen_stores.push_back({o_store_addr, o_store_data});
    end
  end

  function automatic logic [bip_pkg::DATA_WIDTH-1:0] encode(
    input logic [bip_pkg::OPCODE_WIDTH-1:0] op,
    input logic [bip_pkg::OPERAND_WIDTH-1:0] operand
  );
    return {op, operand};
  endfunction

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
    if (got !== expected) begin
      $display("FAIL %s: expected %h, got %h", name, expected, got);
      error_count++;
    end
  endtask

  task automatic load_program();
    foreach (program_words[i]) begin
      @(negedge i_clock);
      i_load_en = 1'b1;
      i_load_addr = bip_pkg::PC_WIDTH'(i);
      i_load_word = program_words[i];
    end
    @(negedge i_clock);
    i_load_en = 1'b0;
  endtask

  // instruction rules applied word by word up to the hlt.
  task automatic predict_program();
    logic [bip_pkg::OPCODE_WIDTH-1:0] op;
    logic [bip_pkg::OPERAND_WIDTH-1:0] operand;
    logic [bip_pkg::DATA_WIDTH-1:0] imm;
    logic [bip_pkg::DATA_ADDR_WIDTH-1:0] addr;
    bit done;
    done = 1'b0;
    expected_stores.delete();
    for (int i = 0; i < program_words.size() && !done; i++) begin
      {op, operand} = program_words[i];
      imm = bip_pkg::DATA_WIDTH'($signed(operand));
      addr = operand[bip_pkg::DATA_ADDR_WIDTH-1:0];
      case (op)
        bip_pkg::OP_HLT: done = 1'b1;
        bip_pkg::OP_STO: begin
          expected_stores.push_back({addr, model_acc});
          model_mem[addr] = model_acc;
          written_addrs.push_back(int'(addr));
        end
        bip_pkg::OP_LD: model_acc = model_mem[addr];
        bip_pkg::OP_LDI: model_acc = imm;
        bip_pkg::OP_ADD: model_acc = model_acc + model_mem[addr];
        bip_pkg::OP_ADDI: model_acc = model_acc + imm;
        bip_pkg::OP_SUB: model_acc = model_acc - model_mem[addr];
        bip_pkg::OP_SUBI: model_acc = model_acc - imm;
        default: ;
      endcase
    end
  endtask

  task automatic run_program();
    logic [bip_pkg::PC_WIDTH-1:0] halt_pc;
    seen_stores.delete();
    @(negedge i_clock);
    i_start = 1'b1;
    @(negedge i_clock);
    i_start = 1'b0;
    while (!o_halted) begin
      @(negedge i_clock);
    end
    halt_pc = o_pc;
    // these cycles also drain the last instructions.
    repeat (4) begin
      @(negedge i_clock);
      compare_value("o_halted", 16'(o_halted), 16'd1);
      compare_value("o_pc", 16'(o_pc), 16'(halt_pc));
    end
  endtask

  task automatic check_results();
    compare_value("o_acc", o_acc, model_acc);
    if (seen_stores.size() != expected_stores.size()) begin
      $display("wrong number of stores: expected %0d, saw %0d",
               expected_stores.size(), seen_stores.size());
      error_count++;
    end else begin
      foreach (seen_stores[i]) begin
        compare_value("o_store_addr", 16'(seen_stores[i].addr), 16'(expected_stores[i].addr));
        compare_value("o_store_data", seen_stores[i].data, expected_stores[i].data);
      end
    end
  endtask

  task automatic build_hand_program();
    program_words.delete();
    program_words.push_back(encode(bip_pkg::OP_LDI, 11'd5));
    program_words.push_back(encode(bip_pkg::OP_ADDI, 11'h7fd));
    // high operand bits are ignored by the data memory.
    program_words.push_back(encode(bip_pkg::OP_STO, 11'h04a));
    program_words.push_back(encode(bip_pkg::OP_LD, 11'd10));
    program_words.push_back(encode(bip_pkg::OP_LDI, 11'h3ff));
    program_words.push_back(encode(bip_pkg::OP_STO, 11'd11));
    program_words.push_back(encode(bip_pkg::OP_ADD, 11'd10));
    program_words.push_back(encode(bip_pkg::OP_SUB, 11'd11));
    // unknown opcode aimed at address 11, read again below.
    program_words.push_back(encode(5'b11111, 11'h14b));
    program_words.push_back(encode(bip_pkg::OP_SUBI, 11'd7));
    program_words.push_back(encode(bip_pkg::OP_STO, 11'd13));
    program_words.push_back(encode(bip_pkg::OP_LDI, 11'h400));
    program_words.push_back(encode(bip_pkg::OP_SUB, 11'd11));
    program_words.push_back(encode(bip_pkg::OP_STO, 11'd12));
    program_words.push_back(encode(bip_pkg::OP_HLT, 11'd0));
    program_words.push_back(encode(bip_pkg::OP_LDI, 11'd1));
  endtask

  task automatic build_random_program(input int count);
    int pick;
    int addr;
    logic [bip_pkg::OPERAND_WIDTH-1:0] operand;
    program_words.delete();
    for (int i = 0; i < count; i++) begin
      pick = $unsigned($random(seed)) % 5;
      operand = bip_pkg::OPERAND_WIDTH'($random(seed));
      case (pick)
        0: program_words.push_back(encode(bip_pkg::OP_LDI, operand));
        1: program_words.push_back(encode(bip_pkg::OP_ADDI, operand));
        2: program_words.push_back(encode(bip_pkg::OP_SUBI, operand));
        3: begin
          program_words.push_back(encode(bip_pkg::OP_STO, operand));
          written_addrs.push_back(int'(operand[bip_pkg::DATA_ADDR_WIDTH-1:0]));
        end
        // loads only read addresses that hold a stored value.
        default: begin
          addr = written_addrs[$unsigned($random(seed)) % written_addrs.size()];
          operand[bip_pkg::DATA_ADDR_WIDTH-1:0] = bip_pkg::DATA_ADDR_WIDTH'(addr);
          program_words.push_back(encode(bip_pkg::OP_LD, operand));
        end
      endcase
    end
    program_words.push_back(encode(bip_pkg::OP_HLT, 11'd0));
  endtask

  initial begin
    seed = 32'hfd27;
    error_count = 0;
    cycle_count = 0;
    model_acc = '0;
    i_clock = 1'b0;
    i_reset = 1'b0;
    i_start = 1'b0;
    i_load_en = 1'b0;
    i_load_addr = '0;
    i_load_word = '0;
    repeat (5) @(negedge i_clock);
    i_reset = 1'b1;
    compare_value("o_store_valid", 16'(o_store_valid), 16'd0);
    compare_value("o_halted", 16'(o_halted), 16'd1);
    compare_value("o_pc", 16'(o_pc), 16'd0);
    compare_value("o_acc", o_acc, 16'd0);

    build_hand_program();
    load_program();
    predict_program();
    run_program();
    check_results();

    build_random_program(40);
    load_program();
    predict_program();
    run_program();
    check_results();

    assert_fails = accumulator_cpu_inst.datapath_inst.datapath_assert_inst.fail_count;
    $display("errors: %0d, assertion failures: %0d", error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/datapath_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath_assert (
  input logic                                i_clock,
  input logic                                i_reset,
  input bip_pkg::control_word_t              i_control,
  input logic [bip_pkg::DATA_WIDTH-1:0]      i_mem_rdata,
  input logic [bip_pkg::DATA_ADDR_WIDTH-1:0] i_mem_addr,
  input logic                                i_mem_we,
  input logic [bip_pkg::DATA_WIDTH-1:0]      i_mem_wdata,
  input logic [bip_pkg::DATA_WIDTH-1:0]      i_acc
);

  int fail_count = 0;
  logic [bip_pkg::DATA_WIDTH-1:0] imm_value;
  logic acc_write;
  logic alu_write;
  logic load_mem;
  logic load_imm;

  // operand bit 10 is the sign.
  assign imm_value = bip_pkg::DATA_WIDTH'($signed(i_control.operand));
  assign acc_write = i_control.valid && i_control.wr_acc;
  assign alu_write = acc_write && (i_control.sel_a == bip_pkg::SEL_A_ALU);
  assign load_mem = acc_write && (i_control.sel_a == bip_pkg::SEL_A_MEM);
  assign load_imm = acc_write && (i_control.sel_a == bip_pkg::SEL_A_IMM);

  task automatic count_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  a_imm_arith: assert property (@(posedge i_clock) disable iff (!i_reset)
    (alu_write && i_control.sel_b) |=> (i_acc == (($past(i_control.alu_op) == bip_pkg::ALU_SUB)
      ? $past(i_acc) - $past(imm_value) : $past(i_acc) + $past(imm_value))))
    else count_failure("immediate add or subtract left a wrong accumulator");

  // memory forms use the read data of the executing cycle.
  a_mem_arith: assert property (@(posedge i_clock) disable iff (!i_reset)
    (alu_write && !i_control.sel_b) |=> (i_acc == (($past(i_control.alu_op) == bip_pkg::ALU_SUB)
      ? $past(i_acc) - $past(i_mem_rdata) : $past(i_acc) + $past(i_mem_rdata))))
    else count_failure("memory add or subtract left a wrong accumulator");

  a_load_mem: assert property (@(posedge i_clock) disable iff (!i_reset)
    load_mem |=> (i_acc == $past(i_mem_rdata)))
    else count_failure("load from memory left a wrong accumulator");

  a_load_imm: assert property (@(posedge i_clock) disable iff (!i_reset)
    load_imm |=> (i_acc == $past(imm_value)))
    else count_failure("load immediate left a wrong accumulator");

  a_store_then_load: assert property (@(posedge i_clock) disable iff (!i_reset)
    (load_mem && $past(i_mem_we) && (i_mem_addr == $past(i_mem_addr)))
      |=> (i_acc == $past(i_mem_wdata, 2)))
    else count_failure("load right after a store did not return the stored value");

  a_store_only_sto: assert property (@(posedge i_clock) disable iff (!i_reset)
    i_mem_we |-> !i_control.wr_acc)
    else count_failure("memory write from a word that also writes the accumulator");

  // a stored word reads back at the same address one cycle later.
  a_store_data: assert property (@(posedge i_clock) disable iff (!i_reset)
    i_mem_we ##1 (i_mem_addr == $past(i_mem_addr)) |-> (i_mem_rdata == $past(i_mem_wdata)))
    else count_failure("stored word did not reach data memory");

endmodule

bind datapath datapath_assert datapath_assert_inst (
  .i_clock     (i_clock),
  .i_reset     (i_reset),
  .i_control   (i_control),
  .i_mem_rdata (i_mem_rdata),
  .i_mem_addr  (o_mem_addr),
  .i_mem_we    (o_mem_we),
  .i_mem_wdata (o_mem_wdata),
  .i_acc       (o_acc)
);

`default_nettype wire

/* logic/accumulator_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module accumulator_cpu (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  logic                                i_start,
  input  logic                                i_load_en,
  input  logic [bip_pkg::PC_WIDTH-1:0]        i_load_addr,
  input  logic [bip_pkg::DATA_WIDTH-1:0]      i_load_word,
  output logic [bip_pkg::DATA_WIDTH-1:0]      o_acc,
  output logic [bip_pkg::PC_WIDTH-1:0]        o_pc,
  output logic                                o_halted,
  output logic                                o_store_valid,
  output logic [bip_pkg::DATA_ADDR_WIDTH-1:0] o_store_addr,
  output logic [bip_pkg::DATA_WIDTH-1:0]      o_store_data
);

  bip_pkg::fetch_word_t fetch_word;
  bip_pkg::control_word_t control_word;
  logic halt_seen;
  logic [bip_pkg::DATA_ADDR_WIDTH-1:0] mem_addr;
  logic mem_we;
  logic [bip_pkg::DATA_WIDTH-1:0] mem_wdata;
  logic [bip_pkg::DATA_WIDTH-1:0] mem_rdata;

  fetch_stage fetch_stage_inst (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_start     (i_start),
    .i_load_en   (i_load_en),
    .i_load_addr (i_load_addr),
    .i_load_word (i_load_word),
    .i_halt_seen (halt_seen),
    .o_fetch     (fetch_word),
    .o_pc        (o_pc),
    .o_halted    (o_halted)
  );

  decode_stage decode_stage_inst (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_fetch     (fetch_word),
    .o_control   (control_word),
    .o_halt_seen (halt_seen)
  );

  datapath datapath_inst (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_control   (control_word),
    .i_mem_rdata (mem_rdata),
    .o_mem_addr  (mem_addr),
    .o_mem_we    (mem_we),
    .o_mem_wdata (mem_wdata),
    .o_acc       (o_acc)
  );

  data_memory data_memory_inst (
    .i_clock (i_clock),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

  // store port mirrors the data memory write.
  assign o_store_valid = mem_we;
  assign o_store_addr = mem_addr;
  assign o_store_data = mem_wdata;

endmodule

`default_nettype wire

/* logic/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
  input  logic                                i_clock,
  input  logic                                i_we,
  input  logic [bip_pkg::DATA_ADDR_WIDTH-1:0] i_addr,
  input  logic [bip_pkg::DATA_WIDTH-1:0]      i_wdata,
  output logic [bip_pkg::DATA_WIDTH-1:0]      o_rdata
);

  logic [bip_pkg::DATA_WIDTH-1:0] mem [bip_pkg::DATA_DEPTH];

  // read is combinational so a store lands before the next load reads.
  assign o_rdata = mem[i_addr];

  always_ff @(posedge i_clock) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                                i_clock,
  input  logic                                i_reset,
  input  bip_pkg::control_word_t              i_control,
  input  logic [bip_pkg::DATA_WIDTH-1:0]      i_mem_rdata,
  output logic [bip_pkg::DATA_ADDR_WIDTH-1:0] o_mem_addr,
  output logic                                o_mem_we,
  output logic [bip_pkg::DATA_WIDTH-1:0]      o_mem_wdata,
  output logic [bip_pkg::DATA_WIDTH-1:0]      o_acc
);

  localparam int EXT_BITS = bip_pkg::DATA_WIDTH - bip_pkg::OPERAND_WIDTH;

  logic [bip_pkg::DATA_WIDTH-1:0] acc;
  logic [bip_pkg::DATA_WIDTH-1:0] imm_ext;
  logic [bip_pkg::DATA_WIDTH-1:0] mux_a;
  logic [bip_pkg::DATA_WIDTH-1:0] mux_b;
  logic [bip_pkg::DATA_WIDTH-1:0] alu_out;

  // replicate the operand sign bit.
  assign imm_ext = {{EXT_BITS{i_control.operand[bip_pkg::OPERAND_WIDTH-1]}},
                    i_control.operand};

  assign mux_b = i_control.sel_b ? imm_ext : i_mem_rdata;

  // wraps modulo 2^16.
  always_comb begin
    case (i_control.alu_op)
      bip_pkg::ALU_ADD: begin
        alu_out = acc + mux_b;
      end
      bip_pkg::ALU_SUB: begin
        alu_out = acc - mux_b;
      end
      default: begin
        alu_out = acc;
      end
    endcase
  end

  always_comb begin
    case (i_control.sel_a)
      bip_pkg::SEL_A_MEM: begin
        mux_a = i_mem_rdata;
      end
      bip_pkg::SEL_A_IMM: begin
        mux_a = imm_ext;
      end
      bip_pkg::SEL_A_ALU: begin
        mux_a = alu_out;
      end
      default: begin
        mux_a = acc;
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      acc <= '0;
    end else if (i_control.valid && i_control.wr_acc) begin
      acc <= mux_a;
    end
  end

  assign o_mem_addr = i_control.operand[bip_pkg::DATA_ADDR_WIDTH-1:0];
  assign o_mem_we = i_control.valid && i_control.wr_mem;
  assign o_mem_wdata = acc;
  assign o_acc = acc;

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                   i_clock,
  input  logic                   i_reset,
  input  bip_pkg::fetch_word_t   i_fetch,
  output bip_pkg::control_word_t o_control,
  output logic                   o_halt_seen
);

  bip_pkg::control_word_t control_d;
  bip_pkg::control_word_t control_q;

  always_comb begin
    control_d = '0;
    control_d.valid = i_fetch.valid;
    control_d.sel_a = bip_pkg::SEL_A_ALU;
    control_d.alu_op = bip_pkg::ALU_PASS;
    control_d.operand = i_fetch.operand;
    case (i_fetch.opcode)
      bip_pkg::OP_STO: begin
        control_d.wr_mem = 1'b1;
      end
      bip_pkg::OP_LD: begin
        control_d.sel_a = bip_pkg::SEL_A_MEM;
        control_d.wr_acc = 1'b1;
      end
      bip_pkg::OP_LDI: begin
        control_d.sel_a = bip_pkg::SEL_A_IMM;
        control_d.sel_b = 1'b1;
        control_d.wr_acc = 1'b1;
      end
      bip_pkg::OP_ADD, bip_pkg::OP_ADDI: begin
        control_d.sel_b = (i_fetch.opcode == bip_pkg::OP_ADDI);
        control_d.alu_op = bip_pkg::ALU_ADD;
        control_d.wr_acc = 1'b1;
      end
      bip_pkg::OP_SUB, bip_pkg::OP_SUBI: begin
        control_d.sel_b = (i_fetch.opcode == bip_pkg::OP_SUBI);
        control_d.alu_op = bip_pkg::ALU_SUB;
        control_d.wr_acc = 1'b1;
      end
      // hlt and unknown opcodes write nothing.
      default: begin
      end
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      control_q <= '0;
    end else begin
      control_q <= control_d;
    end
  end

  assign o_control = control_q;
  assign o_halt_seen = i_fetch.valid && (i_fetch.opcode == bip_pkg::OP_HLT);

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                             i_clock,
  input  logic                             i_reset,
  input  logic                             i_start,
  input  logic                             i_load_en,
  input  logic [bip_pkg::PC_WIDTH-1:0]     i_load_addr,
  input  logic [bip_pkg::DATA_WIDTH-1:0]   i_load_word,
  input  logic                             i_halt_seen,
  output bip_pkg::fetch_word_t             o_fetch,
  output logic [bip_pkg::PC_WIDTH-1:0]     o_pc,
  output logic                             o_halted
);

  logic [bip_pkg::DATA_WIDTH-1:0] prog_mem [bip_pkg::PROG_DEPTH];
  logic [bip_pkg::DATA_WIDTH-1:0] prog_word;
  logic [bip_pkg::PC_WIDTH-1:0] pc;
  logic running;
  logic last_word;
  bip_pkg::fetch_word_t fetch_q;

  assign prog_word = prog_mem[pc];
  assign last_word = (pc == bip_pkg::PC_WIDTH'(bip_pkg::PROG_DEPTH - 1));

  // program load only while idle.
  always_ff @(posedge i_clock) begin
    if (i_load_en && !running) begin
      prog_mem[i_load_addr] <= i_load_word;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      pc <= '0;
      running <= 1'b0;
      fetch_q <= '0;
    end else if (i_start) begin
      pc <= '0;
      running <= 1'b1;
      fetch_q.valid <= 1'b0;
    end else if (running && i_halt_seen) begin
      // word behind the hlt is dropped.
      running <= 1'b0;
      fetch_q.valid <= 1'b0;
    end else if (running) begin
      fetch_q.valid <= 1'b1;
      fetch_q.opcode <= prog_word[bip_pkg::DATA_WIDTH-1:bip_pkg::OPERAND_WIDTH];
      fetch_q.operand <= prog_word[bip_pkg::OPERAND_WIDTH-1:0];
      pc <= pc + 1'b1;
      if (last_word) begin
        running <= 1'b0;
      end
    end else begin
      fetch_q.valid <= 1'b0;
    end
  end

  assign o_fetch = fetch_q;
  assign o_pc = pc;
  assign o_halted = !running;

endmodule

`default_nettype wire

/* logic/bip_pkg.sv */
`default_nettype none

package bip_pkg;

  // instruction fields.
  localparam int OPCODE_WIDTH = 5;
  localparam int OPERAND_WIDTH = 11;

  // accumulator and memory words.
  localparam int DATA_WIDTH = 16;

  // program memory.
  localparam int PROG_DEPTH = 64;
  localparam int PC_WIDTH = 6;

  // data memory, addressed by the low operand bits.
  localparam int DATA_DEPTH = 64;
  localparam int DATA_ADDR_WIDTH = 6;

  localparam logic [OPCODE_WIDTH-1:0] OP_HLT = 5'b00000;
  localparam logic [OPCODE_WIDTH-1:0] OP_STO = 5'b00001;
  localparam logic [OPCODE_WIDTH-1:0] OP_LD = 5'b00010;
  localparam logic [OPCODE_WIDTH-1:0] OP_LDI = 5'b00011;
  localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 5'b00100;
  localparam logic [OPCODE_WIDTH-1:0] OP_ADDI = 5'b00101;
  localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 5'b00110;
  localparam logic [OPCODE_WIDTH-1:0] OP_SUBI = 5'b00111;

  // fetch to decode.
  typedef struct packed {
    logic valid;
    logic [OPCODE_WIDTH-1:0] opcode;
    logic [OPERAND_WIDTH-1:0] operand;
  } fetch_word_t;

  // accumulator source.
  typedef enum logic [1:0] {
    SEL_A_MEM = 2'b00,
    SEL_A_IMM = 2'b01,
    SEL_A_ALU = 2'b10
  } sel_a_t;

  typedef enum logic [1:0] {
    ALU_PASS = 2'b00,
    ALU_ADD = 2'b01,
    ALU_SUB = 2'b10
  } alu_op_t;

  // decode to execute.
  // sel_b low picks memory data, high picks the immediate.
  typedef struct packed {
    logic valid;
    sel_a_t sel_a;
    logic sel_b;
    alu_op_t alu_op;
    logic wr_acc;
    logic wr_mem;
    logic [OPERAND_WIDTH-1:0] operand;
  } control_word_t;

endpackage

`default_nettype wire
